// ==== design/uart_pkg.sv ====
package uart_pkg;

    ////////////////////////////////////////////////////////////
    // Frame format
    ////////////////////////////////////////////////////////////

    localparam int data_bits = 8;
    // Ticks per bit period
    localparam int oversample = 16;
    // One stop bit
    localparam int stop_ticks = 16;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    // Depth 16
    localparam int fifo_addr_bits = 4;
    localparam int divisor_bits = 11;

    typedef logic [data_bits-1:0] byte_t;

    // One received frame, frame_err set on a low stop sample
    typedef struct packed {
        byte_t data;
        logic  frame_err;
    } rx_word_t;

endpackage

// ==== design/fifo_if.sv ====
interface fifo_if #(
    parameter type item_t = uart_pkg::byte_t
) ();

    // Write side
    logic  wr;
    item_t wdata;
    logic  full;

    // Read side, rdata valid whenever empty is low
    logic  rd;
    item_t rdata;
    logic  empty;

    modport producer (
        output wr,
        output wdata,
        input  full
    );

    modport consumer (
        output rd,
        input  rdata,
        input  empty
    );

    // The storage itself sees both ends
    modport fifo (
        input  wr,
        input  wdata,
        output full,
        input  rd,
        output rdata,
        output empty
    );

endinterface

// ==== design/baud_gen.sv ====
module baud_gen (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [uart_pkg::divisor_bits-1:0] divisor,
    output logic                              tick
);

    logic [uart_pkg::divisor_bits-1:0] cnt;

    // Down counter, one tick every divisor+1 clocks
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            // New divisor takes effect at the wrap
            cnt  <= divisor;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

// ==== design/byte_fifo.sv ====
module byte_fifo #(
    parameter type item_t    = uart_pkg::byte_t,
    parameter int  addr_bits = uart_pkg::fifo_addr_bits
) (
    input logic clk,
    input logic reset,
    fifo_if.fifo q
);

    localparam int depth = 1 << addr_bits;

    item_t                mem [depth];
    logic [addr_bits-1:0] wr_ptr;
    logic [addr_bits-1:0] rd_ptr;
    logic [addr_bits:0]   count;
    logic                 push;
    logic                 pop;

    // Strobes against a full or empty queue are dropped here
    assign push = q.wr & ~q.full;
    assign pop  = q.rd & ~q.empty;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= q.wdata;
        end
    end

    // First word fall-through
    assign q.rdata = mem[rd_ptr];

    ////////////////////////////////////////////////////////////
    // Pointers and occupancy
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // count never exceeds depth, so the top bit alone means full
    assign q.full  = count[addr_bits];
    assign q.empty = (count == '0);

endmodule

// ==== design/uart_tx.sv ====
module uart_tx (
    input  logic     clk,
    input  logic     reset,
    input  logic     tick,
    fifo_if.consumer q,
    output logic     tx
);

    localparam int max_ticks = (uart_pkg::stop_ticks > uart_pkg::oversample) ?
                               uart_pkg::stop_ticks : uart_pkg::oversample;
    localparam int s_bits = $clog2(max_ticks);
    localparam int n_bits = $clog2(uart_pkg::data_bits);

    localparam logic [s_bits-1:0] bit_last  = s_bits'(uart_pkg::oversample - 1);
    localparam logic [s_bits-1:0] stop_last = s_bits'(uart_pkg::stop_ticks - 1);
    localparam logic [n_bits-1:0] data_last = n_bits'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {idle, start, data, stop} state_t;

    state_t            state, state_next;
    logic [s_bits-1:0] s_reg, s_next;
    logic [n_bits-1:0] n_reg, n_next;
    uart_pkg::byte_t   b_reg, b_next;
    logic              tx_reg, tx_next;
    logic              tx_start;
    logic              tx_done_tick;

    assign tx_start = ~q.empty;
    // Byte leaves the queue only once its stop bit is out
    assign q.rd     = tx_done_tick;
    assign tx       = tx_reg;

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state  <= idle;
            s_reg  <= '0;
            n_reg  <= '0;
            tx_reg <= 1'b1;
        end else begin
            state  <= state_next;
            s_reg  <= s_next;
            n_reg  <= n_next;
            tx_reg <= tx_next;
        end
    end

    always_ff @(posedge clk) begin
        b_reg <= b_next;
    end

    ////////////////////////////////////////////////////////////
    // Next state logic
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next   = state;
        s_next       = s_reg;
        n_next       = n_reg;
        b_next       = b_reg;
        tx_next      = tx_reg;
        tx_done_tick = 1'b0;

        case (state)
            idle: begin
                tx_next = 1'b1;
                // Start on a tick so the start bit is a whole bit period
                if (tx_start && tick) begin
                    state_next = start;
                    s_next     = '0;
                end
            end
            start: begin
                // Entered straight from stop; back off if the queue ran dry
                if (!tx_start) begin
                    state_next = idle;
                end else begin
                    tx_next = 1'b0;
                    if (tick) begin
                        if (s_reg == bit_last) begin
                            state_next = data;
                            s_next     = '0;
                            n_next     = '0;
                            b_next     = q.rdata;
                        end else begin
                            s_next = s_reg + 1'b1;
                        end
                    end
                end
            end
            data: begin
                tx_next = b_reg[0];
                if (tick) begin
                    if (s_reg == bit_last) begin
                        s_next = '0;
                        b_next = b_reg >> 1;
                        if (n_reg == data_last) begin
                            state_next = stop;
                        end else begin
                            n_next = n_reg + 1'b1;
                        end
                    end else begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            stop: begin
                tx_next = 1'b1;
                if (tick) begin
                    if (s_reg == stop_last) begin
                        tx_done_tick = 1'b1;
                        // Next frame follows with no idle gap
                        state_next   = start;
                        s_next       = '0;
                    end else begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            default: state_next = idle;
        endcase
    end

endmodule

// ==== design/uart_rx.sv ====
module uart_rx (
    input  logic     clk,
    input  logic     reset,
    input  logic     tick,
    input  logic     rx,
    fifo_if.producer q
);

    localparam int s_bits = $clog2(uart_pkg::oversample);
    localparam int n_bits = $clog2(uart_pkg::data_bits);

    localparam logic [s_bits-1:0] half_last = s_bits'(uart_pkg::oversample / 2 - 1);
    localparam logic [s_bits-1:0] bit_last  = s_bits'(uart_pkg::oversample - 1);
    localparam logic [n_bits-1:0] data_last = n_bits'(uart_pkg::data_bits - 1);

    typedef enum logic [1:0] {idle, start, data, stop} state_t;

    state_t            state, state_next;
    logic [s_bits-1:0] s_reg, s_next;
    logic [n_bits-1:0] n_reg, n_next;
    uart_pkg::byte_t   b_reg, b_next;
    logic              rx_meta;
    logic              rx_s;
    logic              line_hi, line_hi_next;
    logic              rx_done_tick;

    // Two-flop synchronizer, idles high
    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
        end
    end

    always_ff @(posedge clk, posedge reset) begin
        if (reset) begin
            state   <= idle;
            s_reg   <= '0;
            n_reg   <= '0;
            line_hi <= 1'b1;
        end else begin
            state   <= state_next;
            s_reg   <= s_next;
            n_reg   <= n_next;
            line_hi <= line_hi_next;
        end
    end

    always_ff @(posedge clk) begin
        b_reg <= b_next;
    end

    ////////////////////////////////////////////////////////////
    // Next state logic
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next   = state;
        s_next       = s_reg;
        n_next       = n_reg;
        b_next       = b_reg;
        line_hi_next = line_hi;
        rx_done_tick = 1'b0;

        case (state)
            idle: begin
                // Line level at the last tick, so only a falling edge starts
                if (tick) begin
                    line_hi_next = rx_s;
                    if (line_hi && !rx_s) begin
                        state_next = start;
                        s_next     = '0;
                    end
                end
            end
            start: begin
                if (tick) begin
                    if (s_reg == half_last) begin
                        if (rx_s) begin
                            // Glitch, line is back high
                            state_next   = idle;
                            line_hi_next = 1'b1;
                        end else begin
                            state_next = data;
                            s_next     = '0;
                            n_next     = '0;
                        end
                    end else begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            data: begin
                if (tick) begin
                    if (s_reg == bit_last) begin
                        s_next = '0;
                        // LSB first
                        b_next = {rx_s, b_reg[uart_pkg::data_bits-1:1]};
                        if (n_reg == data_last) begin
                            state_next = stop;
                        end else begin
                            n_next = n_reg + 1'b1;
                        end
                    end else begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            stop: begin
                // Center of the stop bit
                if (tick) begin
                    if (s_reg == bit_last) begin
                        rx_done_tick = 1'b1;
                        line_hi_next = rx_s;
                        state_next   = idle;
                    end else begin
                        s_next = s_reg + 1'b1;
                    end
                end
            end
            default: state_next = idle;
        endcase
    end

    // Word is dropped by the FIFO when it is full
    assign q.wr    = rx_done_tick;
    assign q.wdata = '{data: b_reg, frame_err: ~rx_s};

endmodule

// ==== design/uart_top.sv ====
module uart_top (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [uart_pkg::divisor_bits-1:0] divisor,
    // Host transmit side
    input  logic                              wr_uart,
    input  uart_pkg::byte_t                   w_data,
    output logic                              tx_full,
    // Host receive side
    input  logic                              rd_uart,
    output uart_pkg::byte_t                   r_data,
    output logic                              rx_frame_err,
    output logic                              rx_empty,
    // Serial lines
    input  logic                              rx,
    output logic                              tx
);

    logic tick;

    fifo_if #(.item_t(uart_pkg::byte_t))   tx_q ();
    fifo_if #(.item_t(uart_pkg::rx_word_t)) rx_q ();

    ////////////////////////////////////////////////////////////
    // Host ends of the queues
    ////////////////////////////////////////////////////////////

    assign tx_q.wr      = wr_uart;
    assign tx_q.wdata   = w_data;
    assign tx_full      = tx_q.full;

    assign rx_q.rd      = rd_uart;
    assign r_data       = rx_q.rdata.data;
    assign rx_frame_err = rx_q.rdata.frame_err;
    assign rx_empty     = rx_q.empty;

    ////////////////////////////////////////////////////////////
    // Tick source
    ////////////////////////////////////////////////////////////

    baud_gen baud_i (
        .clk     (clk),
        .reset   (reset),
        .divisor (divisor),
        .tick    (tick)
    );

    ////////////////////////////////////////////////////////////
    // Transmit path
    ////////////////////////////////////////////////////////////

    byte_fifo #(.item_t(uart_pkg::byte_t)) tx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .q     (tx_q)
    );

    uart_tx tx_i (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .q     (tx_q),
        .tx    (tx)
    );

    ////////////////////////////////////////////////////////////
    // Receive path
    ////////////////////////////////////////////////////////////

    uart_rx rx_i (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .rx    (rx),
        .q     (rx_q)
    );

    // Byte plus its framing flag
    byte_fifo #(.item_t(uart_pkg::rx_word_t)) rx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .q     (rx_q)
    );

endmodule

// ==== tests/uart_tb.sv ====
module uart_tb;

    localparam logic [31:0] seed          = 32'hbc8f;
    localparam int          wait_limit    = 4000;
    localparam int          burst_len     = 16;
    // Oversampling ticks in one bit period
    localparam int          ticks_per_bit = 16;

    logic                              clk;
    logic                              reset;
    logic [uart_pkg::divisor_bits-1:0] divisor;
    logic                              wr_uart;
    uart_pkg::byte_t                   w_data;
    logic                              tx_full;
    logic                              rd_uart;
    uart_pkg::byte_t                   r_data;
    logic                              rx_frame_err;
    logic                              rx_empty;
    logic                              rx;
    logic                              tx;

    // Serial source select between loopback and driven frames
    logic loopback;
    logic drv_rx;

    // Checker controls
    logic            idle_chk;
    logic            mon_on;
    logic            mon_exp;
    logic            rd_chk;
    uart_pkg::byte_t rd_exp;
    logic            rd_exp_err;
    logic            empty_chk;

    logic [31:0]     rng;
    uart_pkg::byte_t sb_q[$];
    uart_pkg::byte_t b;
    int              err_cnt;
    int              test_err;
    int              pass_cnt;
    int              fail_cnt;
    int              k;

    assign rx = loopback ? tx : drv_rx;

    uart_top dut_i (
        .clk          (clk),
        .reset        (reset),
        .divisor      (divisor),
        .wr_uart      (wr_uart),
        .w_data       (w_data),
        .tx_full      (tx_full),
        .rd_uart      (rd_uart),
        .r_data       (r_data),
        .rx_frame_err (rx_frame_err),
        .rx_empty     (rx_empty),
        .rx           (rx),
        .tx           (tx)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Checks sampled mid-cycle
    ////////////////////////////////////////////////////////////

    assert property (@(negedge clk) disable iff (reset)
        idle_chk |-> (tx && !tx_full && rx_empty))
        else flag_err("idle outputs left their reset values");

    assert property (@(negedge clk) disable iff (reset) mon_on |-> (tx == mon_exp))
        else flag_err($sformatf("tx is %b, frame expects %b", tx, mon_exp));

    assert property (@(negedge clk) disable iff (reset)
        rd_chk |-> (r_data == rd_exp))
        else flag_err($sformatf("r_data is %h, expected %h", r_data, rd_exp));

    assert property (@(negedge clk) disable iff (reset)
        rd_chk |-> (rx_frame_err == rd_exp_err))
        else flag_err($sformatf("rx_frame_err is %b, expected %b", rx_frame_err, rd_exp_err));

    assert property (@(negedge clk) disable iff (reset) empty_chk |-> rx_empty)
        else flag_err("rx_empty still low after the last read");

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic flag_err(input string msg);
        $display("ERR %0t %s", $time, msg);
        err_cnt++;
    endtask

    task automatic timed_out(input string what);
        $display("Timeout at %0t: %s never came", $time, what);
        err_cnt++;
    endtask

    // Inputs move 1 unit after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic uart_pkg::byte_t rand_byte();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng[23:16];
    endfunction

    function automatic int bit_clocks();
        return ticks_per_bit * (int'(divisor) + 1);
    endfunction

    task automatic write_byte(input uart_pkg::byte_t data);
        int n;
        n = 0;
        while (tx_full && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (tx_full) begin
            timed_out("tx_full going low");
        end else begin
            wr_uart = 1'b1;
            w_data  = data;
            next_cycle();
            wr_uart = 1'b0;
        end
    endtask

    task automatic read_check(input uart_pkg::byte_t data, input logic ferr);
        int n;
        n = 0;
        while (rx_empty && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (rx_empty) begin
            timed_out("rx_empty going low");
        end else begin
            rd_exp     = data;
            rd_exp_err = ferr;
            rd_chk     = 1'b1;
            rd_uart    = 1'b1;
            next_cycle();
            rd_chk  = 1'b0;
            rd_uart = 1'b0;
        end
    endtask

    task automatic check_drained();
        empty_chk = 1'b1;
        next_cycle();
        empty_chk = 1'b0;
    endtask

    // Expected level on tx for every clock of one frame
    task automatic watch_frame(input uart_pkg::byte_t data, input int bit_clks);
        logic [9:0] frame;
        int         n;
        int         i;
        frame = {1'b1, data, 1'b0};
        n     = 0;
        while (tx && n < wait_limit) begin
            next_cycle();
            n++;
        end
        if (tx) begin
            timed_out("start bit on tx");
        end else begin
            mon_on = 1'b1;
            for (i = 0; i < 10; i++) begin
                mon_exp = frame[i];
                repeat (bit_clks) next_cycle();
            end
            mon_on = 1'b0;
        end
    endtask

    task automatic drive_frame(input uart_pkg::byte_t data, input logic stop_bit,
                               input int bit_clks);
        logic [9:0] frame;
        int         i;
        frame = {stop_bit, data, 1'b0};
        for (i = 0; i < 10; i++) begin
            drv_rx = frame[i];
            repeat (bit_clks) next_cycle();
        end
        // Idle long enough for the receiver to rearm
        drv_rx = 1'b1;
        repeat (2 * bit_clks) next_cycle();
    endtask

    task automatic finish_test(input string name);
        if (err_cnt == test_err) begin
            $display("test %s: pass", name);
            pass_cnt++;
        end else begin
            $display("test %s: FAIL with %0d errors", name, err_cnt - test_err);
            fail_cnt++;
        end
        test_err = err_cnt;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rng        = seed;
        reset      = 1'b1;
        divisor    = 3;
        wr_uart    = 1'b0;
        w_data     = '0;
        rd_uart    = 1'b0;
        drv_rx     = 1'b1;
        loopback   = 1'b0;
        idle_chk   = 1'b0;
        mon_on     = 1'b0;
        mon_exp    = 1'b1;
        rd_chk     = 1'b0;
        rd_exp     = '0;
        rd_exp_err = 1'b0;
        empty_chk  = 1'b0;
        err_cnt    = 0;
        test_err   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        idle_chk = 1'b1;
        repeat (40) next_cycle();
        idle_chk = 1'b0;
        finish_test("reset state");

        // 0x55 puts an edge on every bit boundary
        write_byte(8'h55);
        watch_frame(8'h55, bit_clocks());
        finish_test("frame format");

        loopback = 1'b1;
        b        = rand_byte();
        write_byte(b);
        read_check(b, 1'b0);
        check_drained();
        finish_test("loopback");

        for (k = 0; k < burst_len; k++) begin
            b = rand_byte();
            sb_q.push_back(b);
            write_byte(b);
        end
        while (sb_q.size() > 0) begin
            read_check(sb_q.pop_front(), 1'b0);
        end
        check_drained();
        finish_test("burst");

        loopback = 1'b0;
        b        = rand_byte();
        drive_frame(b, 1'b0, bit_clocks());
        read_check(b, 1'b1);
        b = rand_byte();
        drive_frame(b, 1'b1, bit_clocks());
        read_check(b, 1'b0);
        finish_test("framing error");

        divisor = 0;
        repeat (8) next_cycle();
        loopback = 1'b1;
        b        = rand_byte();
        write_byte(b);
        fork
            watch_frame(b, bit_clocks());
            read_check(b, 1'b0);
        join
        finish_test("divisor change");

        $display("tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
design/uart_pkg.sv
design/fifo_if.sv
design/baud_gen.sv
design/byte_fifo.sv
design/uart_tx.sv
design/uart_rx.sv
design/uart_top.sv
tests/uart_tb.sv

// ==== Bender.yml ====
package:
  name: uart_periph

sources:
  - files:
      - design/uart_pkg.sv
      - design/fifo_if.sv
      - design/baud_gen.sv
      - design/byte_fifo.sv
      - design/uart_tx.sv
      - design/uart_rx.sv
      - design/uart_top.sv
  - target: test
    files:
      - tests/uart_tb.sv
